// ==== source/frontend_pkg.sv ====
package frontend_pkg;

	// Bus and instruction widths
	localparam int W_ADDR = 32;
	localparam int W_DATA = 32;
	localparam int W_HALF = 16;

	// Two entries are enough to keep fetch at full rate while decode stalls
	localparam int FIFO_DEPTH = 2;

	// First fetch address after reset, word aligned
	localparam logic [W_ADDR-1:0] RESET_VECTOR = 32'h0000_0040;

	// One instruction word, read either as a 32-bit format or as a compressed format
	// The compressed register fields overlap, so the wide fields are split into a
	// high part and the 3-bit short field that sits in their low bits
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [4:0] opcode;
			logic [1:0] size;
		} full;
		struct packed {
			logic [15:0] upper;
			logic [2:0]  funct3;
			logic        imm_b12;
			logic [1:0]  rd_rs1_hi;
			logic [2:0]  rs1_short;
			logic [1:0]  rs2_hi;
			logic [2:0]  rs2_short;
			logic [1:0]  quadrant;
		} comp;
	} instr_word_t;

endpackage

// ==== source/fetch_request.sv ====
module fetch_request (
	input  logic                            clk,
	input  logic                            rst_n,
	output logic [frontend_pkg::W_ADDR-1:0] mem_addr,
	output logic                            mem_addr_vld,
	input  logic                            mem_addr_rdy,
	input  logic                            mem_data_vld,
	input  logic [frontend_pkg::W_ADDR-1:0] jump_target,
	input  logic                            jump_target_vld,
	output logic                            jump_target_rdy,
	input  logic                            queue_full,
	input  logic                            queue_almost_full,
	output logic                            jump_now,
	output logic                            resp_live,
	output logic [1:0]                      resp_hwvld
);
	import frontend_pkg::*;

	// Next word address to request, running ahead of the PC
	logic [W_ADDR-1:0] fetch_addr;
	logic              reset_holdoff;
	logic              addr_hold;
	logic              addr_req;
	logic              addr_accept;
	logic              fetch_stall;
	logic [1:0]        pending;
	logic [1:0]        pending_after_resp;
	logic [1:0]        flush_pending;
	// Halfword masks for the address phase and for each outstanding data phase
	logic [1:0]        aph_hwvld;
	logic [1:0]        req_hwvld;
	logic [1:0]        pend_hwvld [2];

	// A held address must not change, so jumps wait until it is accepted
	assign jump_target_rdy = !addr_hold;
	assign jump_now        = jump_target_vld && jump_target_rdy;

	// Registered counts only, so there is no path from the bus ready to the request
	assign fetch_stall = queue_full || (queue_almost_full && |pending) || pending[1];

	// ------------------------------------------------------------------
	// Address phase

	always_comb begin
		mem_addr = fetch_addr;
		addr_req = 1'b0;
		if (addr_hold) begin
			addr_req = 1'b1;
		end else if (jump_target_vld) begin
			// The jump target goes out this cycle unless two responses are still due
			mem_addr = {jump_target[W_ADDR-1:2], 2'b00};
			addr_req = !pending[1];
		end else begin
			addr_req = !fetch_stall;
		end
	end

	assign mem_addr_vld = addr_req && !reset_holdoff;
	assign addr_accept  = mem_addr_vld && mem_addr_rdy;

	// A jump to an odd halfword has no valid low halfword in its first word
	assign req_hwvld = jump_now ? {1'b1, !jump_target[1]} : aph_hwvld;

	// ------------------------------------------------------------------
	// Response tracking

	assign pending_after_resp = pending - {1'b0, mem_data_vld};
	assign resp_live          = mem_data_vld && (flush_pending == 2'd0);
	// Responses come back in order, so the oldest mask belongs to the bus word
	assign resp_hwvld         = pend_hwvld[0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reset_holdoff <= 1'b1;
			addr_hold     <= 1'b0;
			fetch_addr    <= RESET_VECTOR;
			pending       <= 2'd0;
			flush_pending <= 2'd0;
			aph_hwvld     <= 2'b11;
			pend_hwvld[0] <= 2'b11;
			pend_hwvld[1] <= 2'b11;
		end else begin
			reset_holdoff <= 1'b0;
			addr_hold     <= mem_addr_vld && !mem_addr_rdy;
			pending       <= pending_after_resp + {1'b0, addr_accept};

			// Step past the jump target when it was already accepted
			if (jump_now) begin
				fetch_addr <= {jump_target[W_ADDR-1:2] + {{(W_ADDR-3){1'b0}}, addr_accept}, 2'b00};
			end else if (addr_accept) begin
				fetch_addr <= fetch_addr + 4;
			end

			// Everything still in flight at a jump belongs to the old path
			if (jump_now) begin
				flush_pending <= pending_after_resp;
			end else if (mem_data_vld && flush_pending != 2'd0) begin
				flush_pending <= flush_pending - 2'd1;
			end

			if (addr_accept) begin
				aph_hwvld <= 2'b11;
			end else if (jump_now) begin
				aph_hwvld <= {1'b1, !jump_target[1]};
			end

			// Retire the oldest mask, then append the accepted request behind the rest
			if (mem_data_vld) begin
				pend_hwvld[0] <= pend_hwvld[1];
			end
			if (addr_accept) begin
				pend_hwvld[pending_after_resp[0]] <= req_hwvld;
			end
		end
	end

	// The bus never carries more than two responses for us
	assert property (@(posedge clk) disable iff (!rst_n) pending != 2'd3);

	// The memory only answers requests that it accepted earlier
	assert property (@(posedge clk) disable iff (!rst_n) !(mem_data_vld && pending == 2'd0));

	// Only responses that are actually outstanding can be waiting to be dropped
	assert property (@(posedge clk) disable iff (!rst_n) flush_pending <= pending);

endmodule

// ==== source/prefetch_queue.sv ====
module prefetch_queue (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [frontend_pkg::W_DATA-1:0] mem_data,
	input  logic                            mem_data_err,
	input  logic                            resp_live,
	input  logic [1:0]                      resp_hwvld,
	input  logic                            jump_now,
	input  logic                            cir_take,
	output logic [frontend_pkg::W_DATA-1:0] fetch_data,
	output logic [1:0]                      fetch_hwvld,
	output logic                            fetch_err,
	output logic                            fetch_vld,
	output logic                            queue_full,
	output logic                            queue_almost_full
);
	import frontend_pkg::*;

	// Entry 0 is the head, and an entry is valid when any halfword in it is
	logic [W_DATA-1:0]     q_data      [FIFO_DEPTH];
	logic [FIFO_DEPTH-1:0] q_err;
	logic [1:0]            q_hwvld     [FIFO_DEPTH];
	logic [FIFO_DEPTH-1:0] q_valid;
	// What each entry sees one place further up the queue
	logic [W_DATA-1:0]     above_data  [FIFO_DEPTH];
	logic [FIFO_DEPTH-1:0] above_err;
	logic [1:0]            above_hwvld [FIFO_DEPTH];
	logic [FIFO_DEPTH-1:0] above_valid;
	logic [FIFO_DEPTH-1:0] below_valid;
	logic [FIFO_DEPTH-1:0] shift_in;
	logic [FIFO_DEPTH-1:0] load_bus;
	logic                  empty;
	logic                  push;
	logic                  pop;

	always_comb begin
		for (int i = 0; i < FIFO_DEPTH; i++) begin
			q_valid[i] = |q_hwvld[i];
		end
		for (int i = 0; i < FIFO_DEPTH - 1; i++) begin
			above_data[i]  = q_data[i+1];
			above_err[i]   = q_err[i+1];
			above_hwvld[i] = q_hwvld[i+1];
		end
		// Nothing sits above the top entry, so it only ever loads from the bus
		above_data[FIFO_DEPTH-1]  = mem_data;
		above_err[FIFO_DEPTH-1]   = mem_data_err;
		above_hwvld[FIFO_DEPTH-1] = resp_hwvld;
	end

	assign above_valid = {1'b0, q_valid[FIFO_DEPTH-1:1]};
	assign below_valid = {q_valid[FIFO_DEPTH-2:0], 1'b1};

	assign empty             = !q_valid[0];
	assign queue_full        = q_valid[FIFO_DEPTH-1];
	assign queue_almost_full = q_valid[FIFO_DEPTH-2];

	// A response that goes straight into cir is not stored as well
	assign push = resp_live && !(cir_take && empty);
	assign pop  = cir_take && !empty;

	// On a pop the new word lands in the last valid entry, otherwise in the first free one
	always_comb begin
		for (int i = 0; i < FIFO_DEPTH; i++) begin
			shift_in[i] = pop && above_valid[i];
			load_bus[i] = push && !shift_in[i] &&
				(pop ? q_valid[i] : (!q_valid[i] && below_valid[i]));
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < FIFO_DEPTH; i++) begin
				q_hwvld[i] <= 2'b00;
			end
		end else begin
			for (int i = 0; i < FIFO_DEPTH; i++) begin
				if (jump_now) begin
					q_hwvld[i] <= 2'b00;
				end else if (shift_in[i]) begin
					q_hwvld[i] <= above_hwvld[i];
				end else if (load_bus[i]) begin
					q_hwvld[i] <= resp_hwvld;
				end else if (pop && q_valid[i]) begin
					q_hwvld[i] <= 2'b00;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < FIFO_DEPTH; i++) begin
			if (shift_in[i]) begin
				q_data[i] <= above_data[i];
				q_err[i]  <= above_err[i];
			end else if (load_bus[i]) begin
				q_data[i] <= mem_data;
				q_err[i]  <= mem_data_err;
			end
		end
	end

	// Head entry, or the bus itself when nothing is queued
	assign fetch_data  = empty ? mem_data : q_data[0];
	assign fetch_hwvld = empty ? resp_hwvld : q_hwvld[0];
	assign fetch_err   = empty ? mem_data_err : q_err[0];
	assign fetch_vld   = !empty || resp_live;

	// Valid entries always form a run from the head, so q_valid is a thermometer code
	assert property (@(posedge clk) disable iff (!rst_n) ((q_valid + 1'b1) & q_valid) == '0);

endmodule

// ==== source/instr_aligner.sv ====
module instr_aligner (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [frontend_pkg::W_DATA-1:0] fetch_data,
	input  logic [1:0]                      fetch_hwvld,
	input  logic                            fetch_err,
	input  logic                            fetch_vld,
	input  logic [1:0]                      cir_use,
	input  logic                            jump_now,
	output logic [31:0]                     cir,
	output logic [1:0]                      cir_vld,
	output logic [1:0]                      cir_err,
	output logic                            cir_take,
	output frontend_pkg::instr_word_t       next_instr
);
	import frontend_pkg::*;

	// Number of valid halfwords across cir and the spare halfword above it
	logic [1:0]          level;
	logic [1:0]          level_no_fetch;
	logic [1:0]          fill;
	logic [1:0]          level_next;
	logic [W_HALF-1:0]   hwbuf;
	// One error flag per halfword of {hwbuf, cir}
	logic [2:0]          err_q;
	logic [2:0]          err_shifted;
	logic [2:0]          err_next;
	logic [2*W_HALF-1:0] fetch_aligned;
	logic [3*W_HALF-1:0] data_shifted;
	logic [3*W_HALF-1:0] data_next;

	// With only the high halfword valid, it is moved down into the low slot
	assign fetch_aligned = {
		fetch_data[W_HALF +: W_HALF],
		fetch_hwvld[0] ? fetch_data[0 +: W_HALF] : fetch_data[W_HALF +: W_HALF]
	};

	// ------------------------------------------------------------------
	// Shift out what decode consumed

	always_comb begin
		if (cir_use[1]) begin
			data_shifted = {hwbuf, cir[W_HALF +: W_HALF], hwbuf};
			err_shifted  = err_q >> 2;
		end else if (cir_use[0]) begin
			data_shifted = {hwbuf, hwbuf, cir[W_HALF +: W_HALF]};
			err_shifted  = err_q >> 1;
		end else begin
			data_shifted = {hwbuf, cir};
			err_shifted  = err_q;
		end
	end

	assign level_no_fetch = level - cir_use;

	// A half word needs one free slot and a full word needs two
	assign cir_take = level_no_fetch <= (&fetch_hwvld ? 2'd1 : 2'd2);

	// ------------------------------------------------------------------
	// Overlay the fetch word at the first free halfword

	always_comb begin
		data_next = data_shifted;
		err_next  = err_shifted;
		if (cir_take) begin
			case (level_no_fetch)
				2'd2: begin
					data_next = {fetch_aligned[0 +: W_HALF], data_shifted[0 +: 2*W_HALF]};
					err_next  = {fetch_err, err_shifted[1:0]};
				end
				2'd1: begin
					data_next = {fetch_aligned, data_shifted[0 +: W_HALF]};
					err_next  = {{2{fetch_err}}, err_shifted[0]};
				end
				default: begin
					data_next = {data_shifted[2*W_HALF +: W_HALF], fetch_aligned};
					err_next  = {err_shifted[2], {2{fetch_err}}};
				end
			endcase
		end
	end

	assign fill = (cir_take && fetch_vld) ? (&fetch_hwvld ? 2'd2 : 2'd1) : 2'd0;
	assign level_next = jump_now ? 2'd0 : level_no_fetch + fill;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			level   <= 2'd0;
			cir_vld <= 2'd0;
			err_q   <= 3'b000;
		end else begin
			level   <= level_next;
			// A third halfword waits in hwbuf and is not shown to decode yet
			cir_vld <= level_next & ~(level_next >> 1);
			err_q   <= err_next;
		end
	end

	always_ff @(posedge clk) begin
		{hwbuf, cir} <= data_next;
	end

	assign cir_err    = err_q[1:0];
	assign next_instr = data_next[2*W_HALF-1:0];

	// Decode may only take halfwords that were offered in the same cycle
	assert property (@(posedge clk) disable iff (!rst_n) cir_use <= cir_vld);

	// The refill never needs more than the three halfword slots
	assert property (@(posedge clk) disable iff (!rst_n)
		({1'b0, level_no_fetch} + {1'b0, fill}) <= 3'd3);

endmodule

// ==== source/reg_predecode.sv ====
module reg_predecode (
	input  logic                      clk,
	input  logic                      rst_n,
	input  frontend_pkg::instr_word_t next_instr,
	output logic [4:0]                predecode_rs1,
	output logic [4:0]                predecode_rs2
);

	// Combinational register numbers for the word that enters cir next
	logic [4:0] rs1_next;
	logic [4:0] rs2_next;

	// Coarse rule, so a field is picked even when the instruction ignores it
	always_comb begin
		case (next_instr.comp.quadrant)
			2'b11: begin
				rs1_next = next_instr.full.rs1;
				rs2_next = next_instr.full.rs2;
			end
			2'b00: begin
				// Stack pointer based forms use x2
				rs1_next = next_instr.comp.funct3[0] ? {2'b01, next_instr.comp.rs1_short} : 5'd2;
				rs2_next = {2'b01, next_instr.comp.rs2_short};
			end
			2'b01: begin
				rs1_next = next_instr.comp.funct3[2] ? {2'b01, next_instr.comp.rs1_short} :
					{next_instr.comp.rd_rs1_hi, next_instr.comp.rs1_short};
				rs2_next = {2'b01, next_instr.comp.rs2_short};
			end
			default: begin
				rs1_next = next_instr.comp.funct3[1] ? 5'd2 :
					{next_instr.comp.rd_rs1_hi, next_instr.comp.rs1_short};
				rs2_next = {next_instr.comp.rs2_hi, next_instr.comp.rs2_short};
			end
		endcase
	end

	// Registered so the numbers line up with cir
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			predecode_rs1 <= 5'd0;
			predecode_rs2 <= 5'd0;
		end else begin
			predecode_rs1 <= rs1_next;
			predecode_rs2 <= rs2_next;
		end
	end

endmodule

// ==== source/fetch_frontend.sv ====
module fetch_frontend (
	input  logic                            clk,
	input  logic                            rst_n,
	output logic [frontend_pkg::W_ADDR-1:0] mem_addr,
	output logic                            mem_addr_vld,
	input  logic                            mem_addr_rdy,
	input  logic [frontend_pkg::W_DATA-1:0] mem_data,
	input  logic                            mem_data_err,
	input  logic                            mem_data_vld,
	input  logic [frontend_pkg::W_ADDR-1:0] jump_target,
	input  logic                            jump_target_vld,
	output logic                            jump_target_rdy,
	output logic [31:0]                     cir,
	output logic [1:0]                      cir_vld,
	input  logic [1:0]                      cir_use,
	output logic [1:0]                      cir_err,
	output logic [4:0]                      predecode_rs1,
	output logic [4:0]                      predecode_rs2
);
	import frontend_pkg::*;

	// Request unit to queue and aligner
	logic              jump_now;
	logic              resp_live;
	logic [1:0]        resp_hwvld;

	// Queue head, or the bus when the queue is empty
	logic [W_DATA-1:0] fetch_data;
	logic [1:0]        fetch_hwvld;
	logic              fetch_err;
	logic              fetch_vld;
	logic              queue_full;
	logic              queue_almost_full;

	// Aligner back to queue and predecoder
	logic              cir_take;
	instr_word_t       next_instr;

	fetch_request u_fetch_request (
		.clk               (clk),
		.rst_n             (rst_n),
		.mem_addr          (mem_addr),
		.mem_addr_vld      (mem_addr_vld),
		.mem_addr_rdy      (mem_addr_rdy),
		.mem_data_vld      (mem_data_vld),
		.jump_target       (jump_target),
		.jump_target_vld   (jump_target_vld),
		.jump_target_rdy   (jump_target_rdy),
		.queue_full        (queue_full),
		.queue_almost_full (queue_almost_full),
		.jump_now          (jump_now),
		.resp_live         (resp_live),
		.resp_hwvld        (resp_hwvld)
	);

	prefetch_queue u_prefetch_queue (
		.clk               (clk),
		.rst_n             (rst_n),
		.mem_data          (mem_data),
		.mem_data_err      (mem_data_err),
		.resp_live         (resp_live),
		.resp_hwvld        (resp_hwvld),
		.jump_now          (jump_now),
		.cir_take          (cir_take),
		.fetch_data        (fetch_data),
		.fetch_hwvld       (fetch_hwvld),
		.fetch_err         (fetch_err),
		.fetch_vld         (fetch_vld),
		.queue_full        (queue_full),
		.queue_almost_full (queue_almost_full)
	);

	instr_aligner u_instr_aligner (
		.clk         (clk),
		.rst_n       (rst_n),
		.fetch_data  (fetch_data),
		.fetch_hwvld (fetch_hwvld),
		.fetch_err   (fetch_err),
		.fetch_vld   (fetch_vld),
		.cir_use     (cir_use),
		.jump_now    (jump_now),
		.cir         (cir),
		.cir_vld     (cir_vld),
		.cir_err     (cir_err),
		.cir_take    (cir_take),
		.next_instr  (next_instr)
	);

	reg_predecode u_reg_predecode (
		.clk           (clk),
		.rst_n         (rst_n),
		.next_instr    (next_instr),
		.predecode_rs1 (predecode_rs1),
		.predecode_rs2 (predecode_rs2)
	);

endmodule

// ==== test/tb_clock_gen.sv ====
module tb_clock_gen #(
	parameter int PERIOD = 20
) (
	output logic clk
);

	// Free-running clock that starts low at time zero
	initial begin
		clk = 1'b0;
	end

	always begin
		#(PERIOD / 2);
		clk = ~clk;
	end

endmodule

// ==== test/tb_frontend.sv ====
module tb_frontend;
	import frontend_pkg::*;

	localparam int N_INSTR         = 3000;
	localparam int IDLE_LIMIT      = 300;
	localparam int JUMP_WAIT_LIMIT = 50;
	localparam int CYCLE_LIMIT     = 50000;
	localparam int MIN_JUMPS       = 10;
	// Words in this range come back with a bus error
	localparam logic [W_ADDR-1:0] ERR_LO      = 32'h0000_0180;
	localparam logic [W_ADDR-1:0] ERR_HI      = 32'h0000_01a0;
	localparam logic [W_ADDR-1:0] TARGET_MASK = 32'h0000_03fe;

	logic              clk;
	logic              rst_n;
	logic [W_ADDR-1:0] mem_addr;
	logic              mem_addr_vld;
	logic              mem_addr_rdy;
	logic [W_DATA-1:0] mem_data;
	logic              mem_data_err;
	logic              mem_data_vld;
	logic [W_ADDR-1:0] jump_target;
	logic              jump_target_vld;
	logic              jump_target_rdy;
	logic [31:0]       cir;
	logic [1:0]        cir_vld;
	logic [1:0]        cir_use;
	logic [1:0]        cir_err;
	logic [4:0]        predecode_rs1;
	logic [4:0]        predecode_rs2;

	// Memory model state, responses leave in request order
	integer            seed;
	logic [W_ADDR-1:0] resp_addr_q [$];
	int                resp_due_q [$];
	int                cycle;
	int                last_due;
	// Reference state of the fetch address and of the program counter
	logic [W_ADDR-1:0] ref_pc;
	logic [W_ADDR-1:0] exp_fetch;
	logic [W_ADDR-1:0] held_addr;
	logic              addr_held;
	logic              jump_taken;
	int                consumed;
	int                idle_cycles;
	int                jump_wait;
	int                stall_left;
	int                jumps_taken;

	tb_clock_gen #(.PERIOD(20)) u_clock_gen (
		.clk (clk)
	);

	fetch_frontend UUT (
		.clk             (clk),
		.rst_n           (rst_n),
		.mem_addr        (mem_addr),
		.mem_addr_vld    (mem_addr_vld),
		.mem_addr_rdy    (mem_addr_rdy),
		.mem_data        (mem_data),
		.mem_data_err    (mem_data_err),
		.mem_data_vld    (mem_data_vld),
		.jump_target     (jump_target),
		.jump_target_vld (jump_target_vld),
		.jump_target_rdy (jump_target_rdy),
		.cir             (cir),
		.cir_vld         (cir_vld),
		.cir_use         (cir_use),
		.cir_err         (cir_err),
		.predecode_rs1   (predecode_rs1),
		.predecode_rs2   (predecode_rs2)
	);

	// ----------------------------------------------------------------------
	// Reference rules

	// Halfword contents depend only on the halfword address
	// The low two bits come from an address hash, so about a quarter are 32-bit
	function automatic logic [15:0] mem_half(input logic [W_ADDR-1:0] ha);
		logic [1:0] quad;
		quad = ha[2:1] ^ ha[4:3] ^ ha[7:6];
		return {ha[4:1] ^ ha[12:9], ha[5:1], ha[10:6], quad};
	endfunction

	function automatic logic word_err(input logic [W_ADDR-1:0] a);
		return (a >= ERR_LO) && (a < ERR_HI);
	endfunction

	// Coarse rs1 pick, x8 to x15 for the short register fields
	function automatic logic [4:0] coarse_rs1(input logic [31:0] w);
		case (w[1:0])
			2'b11:   return w[19:15];
			2'b00:   return w[13] ? 5'd8 + {2'b00, w[9:7]} : 5'd2;
			2'b01:   return w[15] ? 5'd8 + {2'b00, w[9:7]} : w[11:7];
			default: return w[14] ? 5'd2 : w[11:7];
		endcase
	endfunction

	function automatic logic [4:0] coarse_rs2(input logic [31:0] w);
		case (w[1:0])
			2'b11:   return w[24:20];
			2'b10:   return w[6:2];
			default: return 5'd8 + {2'b00, w[4:2]};
		endcase
	endfunction

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Something failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		fail_run($sformatf("FAILED at time %0t: %s expected 0x%0h, actual 0x%0h",
			$time, name, expected, actual));
	endtask

	// ----------------------------------------------------------------------
	// Inputs, all changed on the falling edge

	task automatic drive_inputs();
		logic [W_ADDR-1:0] a;
		logic [1:0]        size;
		// The bus hands back one response per cycle when it is due
		if (resp_due_q.size() > 0 && resp_due_q[0] == cycle) begin
			a = resp_addr_q.pop_front();
			void'(resp_due_q.pop_front());
			mem_data_vld = 1'b1;
			mem_data     = {mem_half(a + 32'd2), mem_half(a)};
			mem_data_err = word_err(a);
		end else begin
			mem_data_vld = 1'b0;
			mem_data     = $random(seed);
			mem_data_err = 1'b0;
		end
		mem_addr_rdy = ($random(seed) & 3) != 0;

		// A jump request stays up until the frontend takes it
		if (jump_taken) begin
			jump_target_vld = 1'b0;
			jump_taken      = 1'b0;
		end
		if (!jump_target_vld && ($random(seed) & 31) == 0) begin
			jump_target_vld = 1'b1;
			jump_target     = $random(seed) & TARGET_MASK;
		end

		// Decode takes a whole instruction or nothing, with stall bursts now and then
		cir_use = 2'd0;
		if (stall_left > 0) begin
			stall_left--;
		end else if (($random(seed) & 63) == 0) begin
			stall_left = 6 + ($random(seed) & 7);
		end else if (cir_vld != 2'd0) begin
			size = (cir[1:0] == 2'b11) ? 2'd2 : 2'd1;
			if (cir_vld >= size && ($random(seed) & 3) != 0) begin
				cir_use = size;
			end
		end
	endtask

	// ----------------------------------------------------------------------
	// Checks, run while the outputs are settled before the rising edge

	task automatic check_cycle();
		logic accept;
		logic jump_now;
		int   due;
		accept   = mem_addr_vld && mem_addr_rdy;
		jump_now = jump_target_vld && jump_target_rdy;

		// A request that was not accepted must stay exactly as it was
		if (addr_held) begin
			assert (mem_addr_vld === 1'b1) else report_mismatch("mem_addr_vld", 1, mem_addr_vld);
			assert (mem_addr === held_addr) else report_mismatch("mem_addr", held_addr, mem_addr);
		end
		// The jump port is closed exactly while an address is held
		assert (jump_target_rdy === !addr_held)
			else report_mismatch("jump_target_rdy", !addr_held, jump_target_rdy);
		addr_held = mem_addr_vld && !mem_addr_rdy;
		held_addr = mem_addr;

		if (jump_now) begin
			assert (mem_addr === {jump_target[W_ADDR-1:2], 2'b00})
				else report_mismatch("mem_addr", {jump_target[W_ADDR-1:2], 2'b00}, mem_addr);
			exp_fetch  = {jump_target[W_ADDR-1:2], 2'b00};
			jump_taken = 1'b1;
			jump_wait  = 0;
			jumps_taken++;
		end else if (jump_target_vld) begin
			jump_wait++;
			if (jump_wait > JUMP_WAIT_LIMIT) begin
				fail_run("The jump request was not accepted in time");
			end
		end

		// Accepted addresses walk up in words from the reset vector or the last jump
		if (accept) begin
			assert (mem_addr === exp_fetch) else report_mismatch("mem_addr", exp_fetch, mem_addr);
			exp_fetch = mem_addr + 32'd4;
			due = cycle + 1 + ($random(seed) & 1);
			if (due <= last_due) begin
				due = last_due + 1;
			end
			last_due = due;
			resp_addr_q.push_back(mem_addr);
			resp_due_q.push_back(due);
			assert (resp_addr_q.size() <= 2)
				else fail_run("More than two fetch responses are outstanding");
		end

		// Error flags and predecode follow whatever cir shows
		for (int i = 0; i < cir_vld; i++) begin
			assert (cir_err[i] === word_err(ref_pc + W_ADDR'(2 * i)))
				else report_mismatch($sformatf("cir_err[%0d]", i),
					word_err(ref_pc + W_ADDR'(2 * i)), cir_err[i]);
		end
		if (cir_vld != 2'd0) begin
			assert (predecode_rs1 === coarse_rs1(cir))
				else report_mismatch("predecode_rs1", coarse_rs1(cir), predecode_rs1);
			assert (predecode_rs2 === coarse_rs2(cir))
				else report_mismatch("predecode_rs2", coarse_rs2(cir), predecode_rs2);
		end

		// The consumed instruction belongs to the old path even in a jump cycle
		if (cir_use != 2'd0) begin
			assert (cir[15:0] === mem_half(ref_pc))
				else report_mismatch("cir[15:0]", mem_half(ref_pc), cir[15:0]);
			if (cir_use == 2'd2) begin
				assert (cir[31:16] === mem_half(ref_pc + 32'd2))
					else report_mismatch("cir[31:16]", mem_half(ref_pc + 32'd2), cir[31:16]);
			end
			ref_pc = ref_pc + {29'd0, cir_use, 1'b0};
			consumed++;
			idle_cycles = 0;
		end else begin
			idle_cycles++;
		end
		if (jump_now) begin
			ref_pc = jump_target;
		end
	endtask

	// ----------------------------------------------------------------------
	// Main sequence

	initial begin
		seed            = 2;
		rst_n           = 1'b0;
		mem_addr_rdy    = 1'b0;
		mem_data        = '0;
		mem_data_err    = 1'b0;
		mem_data_vld    = 1'b0;
		jump_target     = '0;
		jump_target_vld = 1'b0;
		cir_use         = 2'd0;
		cycle           = 0;
		last_due        = 0;
		ref_pc          = RESET_VECTOR;
		exp_fetch       = RESET_VECTOR;
		held_addr       = '0;
		addr_held       = 1'b0;
		jump_taken      = 1'b0;
		consumed        = 0;
		idle_cycles     = 0;
		jump_wait       = 0;
		stall_left      = 0;
		jumps_taken     = 0;

		repeat (8) @(negedge clk);
		rst_n = 1'b1;

		// First cycle out of reset issues no request and shows no instruction
		#5;
		assert (mem_addr_vld === 1'b0) else report_mismatch("mem_addr_vld", 0, mem_addr_vld);
		assert (cir_vld === 2'd0) else report_mismatch("cir_vld", 0, cir_vld);

		while (consumed < N_INSTR) begin
			@(negedge clk);
			cycle++;
			drive_inputs();
			#5;
			check_cycle();
			if (idle_cycles > IDLE_LIMIT) begin
				fail_run("Decode received no instruction for too many cycles");
			end
			if (cycle > CYCLE_LIMIT) begin
				fail_run("The run took too many cycles");
			end
		end

		if (jumps_taken < MIN_JUMPS) begin
			fail_run("Too few jumps were taken during the run");
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

// ==== all.f ====
source/frontend_pkg.sv
source/fetch_request.sv
source/prefetch_queue.sv
source/instr_aligner.sv
source/reg_predecode.sv
source/fetch_frontend.sv
test/tb_clock_gen.sv
test/tb_frontend.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_frontend
FILE_LIST = all.f
OBJ_DIR   = obj_dir
PASS_MSG  = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
